// ==== source/ipdom_pkg.sv ====
package ipdom_pkg;

    localparam int num_threads      = 4;
    localparam int pc_width         = 16;
    localparam int stack_depth      = 4;   // entry pairs, must be a power of two.
    localparam int stack_addr_width = $clog2(stack_depth);
    localparam int payload_width    = num_threads + 2 * pc_width;

    typedef logic [num_threads-1:0] thread_mask_t;
    typedef logic [pc_width-1:0]    pc_t;

    typedef enum logic [1:0] {
        op_launch = 2'd0,
        op_split  = 2'd1,
        op_join   = 2'd2
    } cmd_op_e;

    typedef struct packed {
        logic [payload_width-num_threads-pc_width-1:0] pad;
        thread_mask_t                                  mask;
        pc_t                                           start_pc;
    } launch_args_t;

    typedef struct packed {
        thread_mask_t pred;       // one predicate bit per thread.
        pc_t          else_pc;
        pc_t          reconv_pc;  // immediate post-dominator of the branch.
    } split_args_t;

    typedef struct packed {
        logic [payload_width-2:0] pad;
        logic                     diverged;
    } join_args_t;

    // the same payload word is read according to the op.
    typedef union packed {
        launch_args_t launch_args;
        split_args_t  split_args;
        join_args_t   join_args;
    } cmd_payload_u;

    typedef struct packed {
        cmd_op_e      op;
        cmd_payload_u payload;
    } cmd_t;

    typedef struct packed {
        thread_mask_t mask;
        pc_t          pc;
    } stack_entry_t;

    typedef enum logic [1:0] {
        st_ok        = 2'd0,
        st_overflow  = 2'd1,
        st_underflow = 2'd2
    } status_e;

    typedef struct packed {
        thread_mask_t mask;
        pc_t          pc;
        logic         diverged;
        status_e      status;
    } resp_t;

endpackage

// ==== source/ipdom_ram.sv ====
module ipdom_ram
    import ipdom_pkg::*;
(
    input  logic                        clk,
    input  logic                        write,
    input  logic [stack_addr_width-1:0] waddr,
    input  stack_entry_t [1:0]          wdata,
    input  logic [stack_addr_width-1:0] raddr,
    output stack_entry_t [1:0]          rdata
);

    stack_entry_t [1:0] mem [stack_depth];  // half 0 else entry, half 1 restore entry.

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // the read is asynchronous so the array maps onto distributed LUT memory.
    assign rdata = mem[raddr];

endmodule

// ==== source/ipdom_stack.sv ====
module ipdom_stack
    import ipdom_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  stack_entry_t else_entry,
    input  stack_entry_t restore_entry,
    input  logic         push,
    input  logic         pop,
    output stack_entry_t top_entry,
    output logic         top_is_restore,
    output logic         empty,
    output logic         full
);

    logic [stack_addr_width-1:0] rd_ptr;
    logic [stack_addr_width-1:0] wr_ptr;
    logic [stack_depth-1:0]      visited;
    logic                        empty_r;
    logic                        full_r;
    stack_entry_t [1:0]          wr_pair;
    stack_entry_t [1:0]          rd_pair;

    assign wr_pair = {restore_entry, else_entry};

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            empty_r <= 1'b1;
            full_r  <= 1'b0;
        end else if (push) begin
            rd_ptr  <= wr_ptr;
            wr_ptr  <= wr_ptr + 1'b1;
            empty_r <= 1'b0;
            full_r  <= (wr_ptr == stack_addr_width'(stack_depth - 1));
        end else if (pop) begin
            // only the second pop of a slot releases it.
            wr_ptr  <= wr_ptr - stack_addr_width'(top_is_restore);
            rd_ptr  <= rd_ptr - stack_addr_width'(top_is_restore);
            empty_r <= (rd_ptr == '0) && top_is_restore;
            full_r  <= full_r && !top_is_restore;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            visited <= '0;
        end else if (push) begin
            visited[wr_ptr] <= 1'b0;
        end else if (pop) begin
            visited[rd_ptr] <= 1'b1;  // next read of this slot yields the restore entry.
        end
    end

    ipdom_ram i_ram (
        .clk   (clk),
        .write (push),
        .waddr (wr_ptr),
        .wdata (wr_pair),
        .raddr (rd_ptr),
        .rdata (rd_pair)
    );

    assign top_is_restore = visited[rd_ptr];
    assign top_entry      = top_is_restore ? rd_pair[1] : rd_pair[0];
    assign empty          = empty_r;
    assign full           = full_r;

    assert property (@(posedge clk) disable iff (reset) push |-> !full_r)
        else $error("push into a full divergence stack.");

    assert property (@(posedge clk) disable iff (reset) pop |-> !empty_r)
        else $error("pop from an empty divergence stack.");

    assert property (@(posedge clk) disable iff (reset) !(push && pop))
        else $error("push and pop in the same cycle.");

endmodule

// ==== source/split_join_unit.sv ====
module split_join_unit
    import ipdom_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         exec,
    input  cmd_t         cmd,
    output logic         done,
    output resp_t        resp,
    output logic         push,
    output logic         pop,
    output stack_entry_t else_entry,
    output stack_entry_t restore_entry,
    input  stack_entry_t top_entry,
    input  logic         top_is_restore,
    input  logic         empty,
    input  logic         full
);

    thread_mask_t mask_r;
    pc_t          pc_r;
    thread_mask_t taken;
    thread_mask_t not_taken;
    logic         divergent;
    logic         is_split;
    logic         is_join;
    thread_mask_t mask_next;
    pc_t          pc_next;
    logic         diverged_next;
    status_e      status_next;

    assign taken     = mask_r & cmd.payload.split_args.pred;
    assign not_taken = mask_r & ~cmd.payload.split_args.pred;
    assign divergent = (taken != '0) && (not_taken != '0);
    assign is_split  = exec && (cmd.op == op_split);
    assign is_join   = exec && (cmd.op == op_join);

    // stack requests are combinational so they land on the same edge as the state.
    assign push = is_split && divergent && !full;
    assign pop  = is_join && cmd.payload.join_args.diverged && !empty;

    assign else_entry    = '{mask: not_taken, pc: cmd.payload.split_args.else_pc};
    assign restore_entry = '{mask: mask_r, pc: cmd.payload.split_args.reconv_pc};

    always_comb begin
        mask_next     = mask_r;
        pc_next       = pc_r;
        diverged_next = 1'b0;
        status_next   = st_ok;
        if (exec) begin
            case (cmd.op)
                op_launch: begin
                    mask_next = cmd.payload.launch_args.mask;
                    pc_next   = cmd.payload.launch_args.start_pc;
                end
                op_split: begin
                    if (taken == '0) begin
                        pc_next = cmd.payload.split_args.else_pc;  // no thread takes the branch.
                    end else if (not_taken == '0) begin
                        pc_next = pc_r + 1'b1;
                    end else if (full) begin
                        status_next = st_overflow;
                    end else begin
                        mask_next     = taken;
                        pc_next       = pc_r + 1'b1;
                        diverged_next = 1'b1;
                    end
                end
                op_join: begin
                    if (!cmd.payload.join_args.diverged) begin
                        pc_next = pc_r + 1'b1;
                    end else if (empty) begin
                        status_next = st_underflow;
                    end else begin
                        // else path first, then the saved mask at the reconvergence pc.
                        mask_next = top_entry.mask;
                        pc_next   = top_entry.pc;
                    end
                end
                default: begin
                    status_next = st_ok;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mask_r <= '0;
            pc_r   <= '0;
            done   <= 1'b0;
        end else begin
            mask_r <= mask_next;
            pc_r   <= pc_next;
            done   <= exec;
        end
    end

    always_ff @(posedge clk) begin
        if (exec) begin
            resp <= '{mask: mask_next, pc: pc_next, diverged: diverged_next,
                      status: status_next};
        end
    end

    // the else entry of a push sits on top of the stack one edge later and has threads to run.
    assert property (@(posedge clk) disable iff (reset)
        push |=> !top_is_restore && (top_entry == $past(else_entry))
                 && (top_entry.mask != '0))
        else $error("divergent push left no runnable else entry on top of the stack.");

    // a restore entry is only consumed after its else entry has been taken.
    assert property (@(posedge clk) disable iff (reset)
        (pop && top_is_restore) |-> (top_entry.mask != '0))
        else $error("restore entry popped with no threads.");

endmodule

// ==== source/cmd_handshake.sv ====
module cmd_handshake
    import ipdom_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  req,
    input  cmd_t  cmd,
    output logic  ack,
    output logic  exec,
    output cmd_t  cmd_q,
    input  logic  done,
    input  resp_t resp_in,
    output resp_t resp
);

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_busy  = 2'd1,
        st_acked = 2'd2
    } hs_state_e;

    hs_state_e state;
    logic      accept;

    assign accept = (state == st_idle) && req && !ack;  // held off until ack is low again.

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            ack   <= 1'b0;
            exec  <= 1'b0;
        end else begin
            exec <= accept;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    if (done) begin
                        ack   <= 1'b1;
                        state <= st_acked;
                    end
                end
                st_acked: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
        if ((state == st_busy) && done) begin
            resp <= resp_in;  // held for as long as ack stays high.
        end
    end

    assert property (@(posedge clk) disable iff (reset) (state == st_busy) |-> (cmd_q == cmd))
        else $error("command input changed while the controller was busy.");

endmodule

// ==== source/divergence_top.sv ====
module divergence_top
    import ipdom_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  req,
    input  cmd_t  cmd,
    output logic  ack,
    output resp_t resp
);

    logic         exec;
    logic         done;
    cmd_t         cmd_q;
    resp_t        core_resp;
    logic         push;
    logic         pop;
    stack_entry_t else_entry;
    stack_entry_t restore_entry;
    stack_entry_t top_entry;
    logic         top_is_restore;
    logic         empty;
    logic         full;

    cmd_handshake i_handshake (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .cmd     (cmd),
        .ack     (ack),
        .exec    (exec),
        .cmd_q   (cmd_q),
        .done    (done),
        .resp_in (core_resp),
        .resp    (resp)
    );

    split_join_unit i_ctrl (
        .clk            (clk),
        .reset          (reset),
        .exec           (exec),
        .cmd            (cmd_q),
        .done           (done),
        .resp           (core_resp),
        .push           (push),
        .pop            (pop),
        .else_entry     (else_entry),
        .restore_entry  (restore_entry),
        .top_entry      (top_entry),
        .top_is_restore (top_is_restore),
        .empty          (empty),
        .full           (full)
    );

    ipdom_stack i_stack (
        .clk            (clk),
        .reset          (reset),
        .else_entry     (else_entry),
        .restore_entry  (restore_entry),
        .push           (push),
        .pop            (pop),
        .top_entry      (top_entry),
        .top_is_restore (top_is_restore),
        .empty          (empty),
        .full           (full)
    );

endmodule

// ==== testbench/tb_divergence.sv ====
module tb_divergence
    import ipdom_pkg::*;
();

    localparam int drive_delay  = 2;
    localparam int wait_limit   = 32;  // cycles allowed for each handshake phase.
    localparam int reset_cycles = 8;

    logic  clk;
    logic  reset;
    logic  req;
    cmd_t  cmd;
    logic  ack;
    resp_t resp;

    int error_count;
    int timeout_count;

    divergence_top i_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .cmd   (cmd),
        .ack   (ack),
        .resp  (resp)
    );

    always #20 clk = ~clk;

    task automatic apply_reset();
        @(posedge clk);
        #drive_delay;
        reset = 1'b1;
        req   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
    endtask

    task automatic check_mask(input string test, input thread_mask_t exp, input thread_mask_t act);
        if (act !== exp) begin
            $display("mismatch %s mask: expected %h, actual %h", test, exp, act);
            error_count++;
        end
    endtask

    task automatic check_pc(input string test, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("mismatch %s pc: expected %h, actual %h", test, exp, act);
            error_count++;
        end
    endtask

    task automatic check_status(input string test, input status_e exp, input status_e act);
        if (act !== exp) begin
            $display("mismatch %s status: expected %0d, actual %0d", test, exp, act);
            error_count++;
        end
    endtask

    task automatic check_flag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s diverged: expected %b, actual %b", test, exp, act);
            error_count++;
        end
    endtask

    // one full four-phase transfer; ok stays low if either phase times out.
    task automatic send_command(input string test, input cmd_t c, output resp_t r,
                                output logic ok);
        int cycles;
        ok = 1'b0;
        r  = '0;
        @(posedge clk);
        #drive_delay;
        cmd    = c;
        req    = 1'b1;
        cycles = 0;
        while (!ack && cycles < wait_limit) begin
            @(posedge clk);
            #drive_delay;
            cycles++;
        end
        if (!ack) begin
            $display("timeout in %s: ack never rose after req was raised.", test);
            timeout_count++;
            req = 1'b0;
            return;
        end
        r      = resp;  // resp is held while ack is high.
        req    = 1'b0;
        cycles = 0;
        while (ack && cycles < wait_limit) begin
            @(posedge clk);
            #drive_delay;
            cycles++;
        end
        if (ack) begin
            $display("timeout in %s: ack stayed high after req was dropped.", test);
            timeout_count++;
        end else begin
            ok = 1'b1;
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        string       name;
        string       op;
        logic [31:0] arg0;
        logic [31:0] arg1;
        logic [31:0] arg2;
        logic [31:0] exp_mask;
        logic [31:0] exp_pc;
        logic [31:0] exp_div;
        logic [31:0] exp_status;
        cmd_t        c;
        resp_t       r;
        logic        ok;
        logic        stop;
        clk           = 1'b0;
        reset         = 1'b1;
        req           = 1'b0;
        cmd           = '0;
        error_count   = 0;
        timeout_count = 0;
        stop          = 1'b0;
        apply_reset();
        fd = $fopen("testbench/divergence_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/divergence_input.txt.");
            error_count++;
            stop = 1'b1;
        end
        while (!stop && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h", name, op, arg0, arg1, arg2,
                             exp_mask, exp_pc, exp_div, exp_status);
            if (fields != 9) begin
                $display("malformed line in the stimulus file: %s", line);
                error_count++;
                continue;
            end
            if (op == "reset") begin
                apply_reset();  // the row's expected columns are unused.
                continue;
            end
            c = '0;
            if (op == "launch") begin
                c.op                           = op_launch;
                c.payload.launch_args.mask     = thread_mask_t'(arg0);
                c.payload.launch_args.start_pc = pc_t'(arg1);
            end else if (op == "split") begin
                c.op                           = op_split;
                c.payload.split_args.pred      = thread_mask_t'(arg0);
                c.payload.split_args.else_pc   = pc_t'(arg1);
                c.payload.split_args.reconv_pc = pc_t'(arg2);
            end else if (op == "join") begin
                c.op                          = op_join;
                c.payload.join_args.diverged = arg0[0];
            end else begin
                $display("unknown command %s in test %s.", op, name);
                error_count++;
                continue;
            end
            send_command(name, c, r, ok);
            if (!ok) begin
                stop = 1'b1;
            end else begin
                check_mask(name, thread_mask_t'(exp_mask), r.mask);
                check_pc(name, pc_t'(exp_pc), r.pc);
                check_flag(name, exp_div[0], r.diverged);
                check_status(name, status_e'(exp_status[1:0]), r.status);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/ipdom_pkg.sv
source/ipdom_ram.sv
source/ipdom_stack.sv
source/split_join_unit.sv
source/cmd_handshake.sv
source/divergence_top.sv
testbench/tb_divergence.sv

// ==== testbench/divergence_input.txt ====
# name op arg0 arg1 arg2 exp_mask exp_pc exp_diverged exp_status, all numbers in hex
# launch: mask start_pc -; split: pred else_pc reconv_pc; join: diverged - -; status 0 ok 1 over 2 under
launch_all         launch f 0100 0000 f 0100 0 0
split_all_taken    split  f 0200 0300 f 0101 0 0
split_none_taken   split  0 0180 0190 f 0180 0 0
join_uniform       join   0 0000 0000 f 0181 0 0
split_divergent    split  3 0400 0500 3 0182 1 0
join_else_path     join   1 0000 0000 c 0400 0 0
join_restore       join   1 0000 0000 f 0500 0 0
join_empty         join   1 0000 0000 f 0500 0 2
launch_nest        launch f 1000 0000 f 1000 0 0
nest_1             split  e 1100 1900 e 1001 1 0
nest_2             split  6 1200 1800 6 1002 1 0
nest_3             split  2 1300 1700 2 1003 1 0
relaunch           launch f 2000 0000 f 2000 0 0
nest_4             split  3 2100 2900 3 2001 1 0
nest_5_overflow    split  1 2200 2300 3 2001 0 1
unwind_4_else      join   1 0000 0000 c 2100 0 0
unwind_4_restore   join   1 0000 0000 f 2900 0 0
unwind_3_else      join   1 0000 0000 4 1300 0 0
unwind_3_restore   join   1 0000 0000 6 1700 0 0
unwind_2_else      join   1 0000 0000 8 1200 0 0
unwind_2_restore   join   1 0000 0000 e 1800 0 0
unwind_1_else      join   1 0000 0000 1 1100 0 0
unwind_1_restore   join   1 0000 0000 f 1900 0 0
join_underflow     join   1 0000 0000 f 1900 0 2
launch_pre_reset   launch f 3000 0000 f 3000 0 0
split_pre_reset    split  5 3100 3200 5 3001 1 0
mid_reset          reset  0 0000 0000 0 0000 0 0
join_after_reset   join   1 0000 0000 0 0000 0 2
join_flat_reset    join   0 0000 0000 0 0001 0 0
launch_post_reset  launch 7 0040 0000 7 0040 0 0
split_post_reset   split  1 0050 0060 1 0041 1 0
join_post_else     join   1 0000 0000 6 0050 0 0
join_post_restore  join   1 0000 0000 7 0060 0 0
